/* source/rename_cfg.svh */
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// Architectural and physical register file sizes
`define RENAME_ARCH_REGS 32
`define RENAME_PHYS_REGS 64

// Instruction ids that may be in flight at once
`define RENAME_IDS 32

// Address widths tied to the sizes above
`define RENAME_ARCH_W 5
`define RENAME_PHYS_W 6
`define RENAME_ID_W 5

// Post-reset init length, one table entry per cycle
`define RENAME_INIT_CYCLES 32

`endif

/* source/rename_types_pkg.sv */
`default_nettype none

`include "rename_cfg.svh"

package rename_types_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Address types
    typedef logic [`RENAME_ARCH_W-1:0] arch_addr_t;
    typedef logic [`RENAME_PHYS_W-1:0] phys_addr_t;
    typedef logic [`RENAME_ID_W-1:0]   inst_id_t;

    ////////////////////////////////////////////////////////////////////////////
    // Packets on the ports

    // Rename request from decode
    typedef struct packed {
        inst_id_t   id;
        arch_addr_t rs1;
        arch_addr_t rs2;
        arch_addr_t rd;
        logic       uses_rd;
    } rename_req_t;

    // Retire of one id, commit or discard
    typedef struct packed {
        inst_id_t id;
        logic     discard;
    } retire_t;

    // Renamed sources and new destination
    typedef struct packed {
        inst_id_t   id;
        phys_addr_t phys_rs1;
        phys_addr_t phys_rs2;
        phys_addr_t phys_rd;
    } rename_rsp_t;

    // In-use table entry, rd zero marks no rename
    typedef struct packed {
        arch_addr_t rd;
        phys_addr_t spec_phys;
        phys_addr_t prev_phys;
    } inuse_entry_t;

endpackage

`default_nettype wire

/* source/rename_ctrl_pkg.sv */
`default_nettype none

package rename_ctrl_pkg;

    // Init sequencer
    typedef enum logic [0:0] {
        INIT_CLEAR = 1'b0,
        INIT_RUN   = 1'b1
    } init_state_t;

    // Speculative table write source
    // Priority init, then discard, then rename
    typedef enum logic [1:0] {
        SRC_NONE    = 2'd0,
        SRC_RENAME  = 2'd1,
        SRC_DISCARD = 2'd2,
        SRC_INIT    = 2'd3
    } spec_src_t;

endpackage

`default_nettype wire

/* source/free_list.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_cfg.svh"

module free_list (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          push,
    input  rename_types_pkg::phys_addr_t push_data,
    input  wire                          pop,
    output rename_types_pkg::phys_addr_t head
);

    // One slot per register beyond the identity set
    localparam int DEPTH = `RENAME_PHYS_REGS - `RENAME_ARCH_REGS;

    rename_types_pkg::phys_addr_t mem [DEPTH];
    logic [`RENAME_ARCH_W-1:0]    wr_ptr;
    logic [`RENAME_ARCH_W-1:0]    rd_ptr;

    ////////////////////////////////////////////////////////////////////////////
    // Pointers
    // Wrap naturally at DEPTH, push and pop are independent
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Oldest entry, read without a clock
    assign head = mem[rd_ptr];

endmodule

`default_nettype wire

/* source/rename_front.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_cfg.svh"

module rename_front (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          req_valid,
    input  rename_types_pkg::rename_req_t req,
    input  wire                          retire_valid,
    input  rename_types_pkg::retire_t     retire,
    output logic                         req_q_valid,
    output rename_types_pkg::rename_req_t req_q,
    output logic                         rename_rd,
    output logic                         retire_q_valid,
    output rename_types_pkg::retire_t     retire_q,
    output logic                         init_active,
    output rename_types_pkg::arch_addr_t  init_index,
    output logic                         ready
);

    rename_ctrl_pkg::init_state_t state;
    logic                         init_last;

    ////////////////////////////////////////////////////////////////////////////
    // Init sequencer
    // Walks every arch register once after reset
    assign init_last   = (init_index == `RENAME_ARCH_W'(`RENAME_INIT_CYCLES - 1));
    assign init_active = (state == rename_ctrl_pkg::INIT_CLEAR);
    assign ready       = (state == rename_ctrl_pkg::INIT_RUN);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= rename_ctrl_pkg::INIT_CLEAR;
            init_index <= '0;
        end else if (state == rename_ctrl_pkg::INIT_CLEAR) begin
            init_index <= init_index + 1'b1;
            // Last index written this cycle
            if (init_last) begin
                state <= rename_ctrl_pkg::INIT_RUN;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Input strobes
    // Dropped while init is still running
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q_valid    <= 1'b0;
            rename_rd      <= 1'b0;
            retire_q_valid <= 1'b0;
        end else begin
            req_q_valid    <= req_valid & ready;
            // x0 is never renamed
            rename_rd      <= req_valid & ready & req.uses_rd & (|req.rd);
            retire_q_valid <= retire_valid & ready;
        end
    end

    // Packets, only meaningful beside their strobe
    always_ff @(posedge clk) begin
        if (req_valid) begin
            req_q <= req;
        end
        if (retire_valid) begin
            retire_q <= retire;
        end
    end

endmodule

`default_nettype wire

/* source/register_renamer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_cfg.svh"

module register_renamer (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           req_q_valid,
    input  rename_types_pkg::rename_req_t  req_q,
    input  wire                           rename_rd,
    input  wire                           retire_q_valid,
    input  rename_types_pkg::retire_t      retire_q,
    input  wire                           init_active,
    input  rename_types_pkg::arch_addr_t   init_index,
    output logic                          rsp_next_valid,
    output rename_types_pkg::rename_rsp_t  rsp_next,
    output logic                          free_push
);

    // Speculative arch to phys map
    rename_types_pkg::phys_addr_t   spec_table [`RENAME_ARCH_REGS];
    // Per id record of the destination rename
    rename_types_pkg::inuse_entry_t inuse_table [`RENAME_IDS];

    rename_types_pkg::phys_addr_t   spec_rs1;
    rename_types_pkg::phys_addr_t   spec_rs2;
    rename_types_pkg::phys_addr_t   spec_rd_prev;

    rename_types_pkg::inuse_entry_t inuse_next;
    rename_types_pkg::inuse_entry_t retire_entry;

    rename_ctrl_pkg::spec_src_t     spec_src;
    rename_types_pkg::arch_addr_t   spec_waddr;
    rename_types_pkg::phys_addr_t   spec_wdata;

    rename_types_pkg::phys_addr_t   free_head;
    rename_types_pkg::phys_addr_t   fl_push_data;
    logic                           fl_push;

    ////////////////////////////////////////////////////////////////////////////
    // Free list
    // Init loads 32..63, retires push at the tail
    assign fl_push      = init_active | free_push;
    assign fl_push_data = init_active      ? {1'b1, init_index} :
                          retire_q.discard ? retire_entry.spec_phys :
                                             retire_entry.prev_phys;

    free_list free_list0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (fl_push),
        .push_data (fl_push_data),
        .pop       (rename_rd),
        .head      (free_head)
    );

    ////////////////////////////////////////////////////////////////////////////
    // In-use table
    // Written for every request so a stale entry never frees anything
    assign inuse_next = '{
        rd:        rename_rd ? req_q.rd : '0,
        spec_phys: free_head,
        prev_phys: spec_rd_prev
    };

    always_ff @(posedge clk) begin
        if (req_q_valid) begin
            inuse_table[req_q.id] <= inuse_next;
        end
    end

    // Asynchronous read at retire
    assign retire_entry = inuse_table[retire_q.id];

    // Only ids that renamed a destination give a register back
    assign free_push = retire_q_valid & (|retire_entry.rd);

    ////////////////////////////////////////////////////////////////////////////
    // Speculative table
    // Three read ports
    // The rd port yields the mapping being replaced
    assign spec_rs1     = spec_table[req_q.rs1];
    assign spec_rs2     = spec_table[req_q.rs2];
    assign spec_rd_prev = spec_table[req_q.rd];

    // Write source select
    // Discard never meets a rename
    always_comb begin
        if (init_active) begin
            spec_src = rename_ctrl_pkg::SRC_INIT;
        end else if (free_push & retire_q.discard) begin
            spec_src = rename_ctrl_pkg::SRC_DISCARD;
        end else if (rename_rd) begin
            spec_src = rename_ctrl_pkg::SRC_RENAME;
        end else begin
            spec_src = rename_ctrl_pkg::SRC_NONE;
        end
    end

    always_comb begin
        case (spec_src)
            // Identity map, lower 32 registers
            rename_ctrl_pkg::SRC_INIT: begin
                spec_waddr = init_index;
                spec_wdata = {1'b0, init_index};
            end
            // Restore the mapping from before the rename
            rename_ctrl_pkg::SRC_DISCARD: begin
                spec_waddr = retire_entry.rd;
                spec_wdata = retire_entry.prev_phys;
            end
            rename_ctrl_pkg::SRC_RENAME: begin
                spec_waddr = req_q.rd;
                spec_wdata = free_head;
            end
            // No write this cycle
            default: begin
                spec_waddr = '0;
                spec_wdata = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (spec_src != rename_ctrl_pkg::SRC_NONE) begin
            spec_table[spec_waddr] <= spec_wdata;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Response
    // Sources see mappings from before this request's own rd
    assign rsp_next_valid = req_q_valid;
    assign rsp_next = '{
        id:       req_q.id,
        phys_rs1: spec_rs1,
        phys_rs2: spec_rs2,
        phys_rd:  rename_rd ? free_head : '0
    };

endmodule

`default_nettype wire

/* source/rename_out.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_cfg.svh"

module rename_out (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          rsp_next_valid,
    input  rename_types_pkg::rename_rsp_t rsp_next,
    input  wire                          retire_q_valid,
    output logic                         rsp_valid,
    output rename_types_pkg::rename_rsp_t rsp,
    output logic [`RENAME_ID_W:0]        ids_in_flight
);

    ////////////////////////////////////////////////////////////////////////////
    // Response register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rsp_next_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_next_valid) begin
            rsp <= rsp_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outstanding ids
    // Up on response, down on retire, both cancel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ids_in_flight <= '0;
        end else begin
            case ({rsp_next_valid, retire_q_valid})
                2'b10:   ids_in_flight <= ids_in_flight + 1'b1;
                2'b01:   ids_in_flight <= ids_in_flight - 1'b1;
                default: ids_in_flight <= ids_in_flight;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/rename_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_cfg.svh"

module rename_top (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          req_valid,
    input  rename_types_pkg::rename_req_t req,
    input  wire                          retire_valid,
    input  rename_types_pkg::retire_t     retire,
    output logic                         rsp_valid,
    output rename_types_pkg::rename_rsp_t rsp,
    output logic                         ready,
    output logic [`RENAME_ID_W:0]        ids_in_flight
);

    // Front to renamer
    logic                          req_q_valid;
    rename_types_pkg::rename_req_t req_q;
    logic                          rename_rd;
    logic                          retire_q_valid;
    rename_types_pkg::retire_t     retire_q;
    logic                          init_active;
    rename_types_pkg::arch_addr_t  init_index;

    // Renamer to output stage
    logic                          rsp_next_valid;
    rename_types_pkg::rename_rsp_t rsp_next;

    rename_front front0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req            (req),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .req_q_valid    (req_q_valid),
        .req_q          (req_q),
        .rename_rd      (rename_rd),
        .retire_q_valid (retire_q_valid),
        .retire_q       (retire_q),
        .init_active    (init_active),
        .init_index     (init_index),
        .ready          (ready)
    );

    // Free strobe only steers the free list inside the renamer
    register_renamer renamer0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_q_valid    (req_q_valid),
        .req_q          (req_q),
        .rename_rd      (rename_rd),
        .retire_q_valid (retire_q_valid),
        .retire_q       (retire_q),
        .init_active    (init_active),
        .init_index     (init_index),
        .rsp_next_valid (rsp_next_valid),
        .rsp_next       (rsp_next),
        .free_push      ()
    );

    rename_out out0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .rsp_next_valid (rsp_next_valid),
        .rsp_next       (rsp_next),
        .retire_q_valid (retire_q_valid),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .ids_in_flight  (ids_in_flight)
    );

endmodule

`default_nettype wire

/* test/rename_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_cfg.svh"

module rename_checker (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          rsp_valid,
    input  rename_types_pkg::rename_rsp_t rsp,
    input  wire                          ready,
    input  wire [`RENAME_ID_W:0]         ids_in_flight
);

    // Error counts by kind
    int mismatch_count   = 0;
    int missing_count    = 0;
    int unexpected_count = 0;
    int other_count      = 0;

    // Expected responses in request order
    rename_types_pkg::rename_rsp_t exp_q [$];
    string                         name_q [$];

    rename_types_pkg::rename_rsp_t exp_rsp;
    string                         exp_name;

    // Init length tracking
    int   init_cycles = 0;
    logic ready_seen  = 1'b0;
    logic ready_lost  = 1'b0;

    ////////////////////////////////////////////////////////////////////////////
    // Hooks called from the testbench top

    // Queued at drive time, popped when the response shows up
    task automatic expect_rsp(input string name, input rename_types_pkg::rename_rsp_t exp);
        name_q.push_back(name);
        exp_q.push_back(exp);
    endtask

    // Counter is stable on the falling edge
    task automatic expect_flight(input string name, input logic [`RENAME_ID_W:0] exp);
        if (ids_in_flight !== exp) begin
            $display("Mismatch %s: ids_in_flight expected %0d, actual %0d",
                     name, exp, ids_in_flight);
            mismatch_count++;
        end
    endtask

    // Anything still queued never got its response
    task automatic check_drained();
        while (exp_q.size() > 0) begin
            exp_rsp  = exp_q.pop_front();
            exp_name = name_q.pop_front();
            $display("Missing response for %s, id %0d never came back", exp_name, exp_rsp.id);
            missing_count++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Response compare
    always @(posedge clk) begin
        if (rst_n && rsp_valid) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected response with id %0d while no request was pending",
                         rsp.id);
                unexpected_count++;
            end else begin
                exp_rsp  = exp_q.pop_front();
                exp_name = name_q.pop_front();
                if (rsp !== exp_rsp) begin
                    $write("Mismatch %s: expected id %0d rs1 %0d rs2 %0d rd %0d",
                           exp_name, exp_rsp.id, exp_rsp.phys_rs1,
                           exp_rsp.phys_rs2, exp_rsp.phys_rd);
                    $display(", actual id %0d rs1 %0d rs2 %0d rd %0d",
                             rsp.id, rsp.phys_rs1, rsp.phys_rs2, rsp.phys_rd);
                    mismatch_count++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Ready after init
    // Low for exactly the init length, then high for good
    always @(posedge clk) begin
        if (rst_n) begin
            if (ready) begin
                if (!ready_seen && init_cycles != `RENAME_INIT_CYCLES) begin
                    $display("ready rose after %0d init cycles instead of %0d",
                             init_cycles, `RENAME_INIT_CYCLES);
                    other_count++;
                end
                ready_seen = 1'b1;
            end else if (ready_seen) begin
                if (!ready_lost) begin
                    $display("ready dropped after init had finished");
                    other_count++;
                end
                ready_lost = 1'b1;
            end else begin
                init_cycles++;
                if (init_cycles == `RENAME_INIT_CYCLES + 1) begin
                    $display("ready did not rise after %0d init cycles", `RENAME_INIT_CYCLES);
                    other_count++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_rename_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_cfg.svh"

module tb_rename_top;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_LINES    = 256;

    // One stimulus line, driven for one cycle
    typedef struct packed {
        logic                          req_valid;
        rename_types_pkg::rename_req_t req;
        logic                          retire_valid;
        rename_types_pkg::retire_t     retire;
        rename_types_pkg::rename_rsp_t exp_rsp;
        logic signed [7:0]             exp_flight;
    } stim_line_t;

    logic                          clk;
    logic                          rst_n;
    logic                          req_valid;
    rename_types_pkg::rename_req_t req;
    logic                          retire_valid;
    rename_types_pkg::retire_t     retire;
    logic                          rsp_valid;
    rename_types_pkg::rename_rsp_t rsp;
    logic                          ready;
    logic [`RENAME_ID_W:0]         ids_in_flight;

    stim_line_t stim [MAX_LINES];
    string      names [MAX_LINES];
    int         n_lines     = 0;
    int         load_errors = 0;
    logic       stim_loaded = 1'b0;

    rename_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req           (req),
        .retire_valid  (retire_valid),
        .retire        (retire),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .ready         (ready),
        .ids_in_flight (ids_in_flight)
    );

    rename_checker chk0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .ready         (ready),
        .ids_in_flight (ids_in_flight)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Clock and watchdog
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Budget covers reset, init and drain on top of the lines
    initial begin
        wait (stim_loaded);
        #((n_lines + 64) * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", n_lines + 64);
        $display("*** FAILED ***");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus file
    // Comment lines start with #, every other line has 14 fields
    task automatic load_stimulus();
        int    fd;
        int    n;
        string line;
        string name;
        int    rv, id, rs1, rs2, rd, urd;
        int    tv, tid, dis;
        int    ers1, ers2, erd, eflt;
        fd = $fopen("test/rename_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open test/rename_input.txt for reading");
            load_errors++;
        end else begin
            while (!$feof(fd) && n_lines < MAX_LINES) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d", name,
                                rv, id, rs1, rs2, rd, urd, tv, tid, dis, ers1, ers2, erd, eflt);
                    if (n != 14) begin
                        $display("Stimulus line %0d has %0d fields instead of 14", n_lines, n);
                        load_errors++;
                    end else begin
                        names[n_lines]                 = name;
                        stim[n_lines].req_valid        = rv[0];
                        stim[n_lines].req.id           = id[4:0];
                        stim[n_lines].req.rs1          = rs1[4:0];
                        stim[n_lines].req.rs2          = rs2[4:0];
                        stim[n_lines].req.rd           = rd[4:0];
                        stim[n_lines].req.uses_rd      = urd[0];
                        stim[n_lines].retire_valid     = tv[0];
                        stim[n_lines].retire.id        = tid[4:0];
                        stim[n_lines].retire.discard   = dis[0];
                        // Response carries the request id back
                        stim[n_lines].exp_rsp.id       = id[4:0];
                        stim[n_lines].exp_rsp.phys_rs1 = ers1[5:0];
                        stim[n_lines].exp_rsp.phys_rs2 = ers2[5:0];
                        stim[n_lines].exp_rsp.phys_rd  = erd[5:0];
                        stim[n_lines].exp_flight       = eflt[7:0];
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Falling edge drive, expectations go to the checker
    task automatic drive_line(input int i);
        req_valid    = stim[i].req_valid;
        req          = stim[i].req;
        retire_valid = stim[i].retire_valid;
        retire       = stim[i].retire;
        if (stim[i].req_valid) begin
            chk0.expect_rsp(names[i], stim[i].exp_rsp);
        end
        // Negative flight value means not checked on this line
        if (stim[i].exp_flight >= 0) begin
            chk0.expect_flight(names[i], stim[i].exp_flight[`RENAME_ID_W:0]);
        end
    endtask

    task automatic finish_run();
        int total;
        total = load_errors + chk0.mismatch_count + chk0.missing_count +
                chk0.unexpected_count + chk0.other_count;
        $display("Errors: %0d mismatch, %0d missing, %0d unexpected, %0d other, %0d stimulus",
                 chk0.mismatch_count, chk0.missing_count, chk0.unexpected_count,
                 chk0.other_count, load_errors);
        if (total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        retire_valid = 1'b0;
        retire       = '0;
        load_stimulus();
        stim_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Nothing is sent before init is over
        @(negedge clk);
        while (!ready) @(negedge clk);

        for (int i = 0; i < n_lines; i++) begin
            drive_line(i);
            @(negedge clk);
        end
        req_valid    = 1'b0;
        retire_valid = 1'b0;

        // Two-cycle response latency plus margin
        repeat (4) @(negedge clk);
        chk0.check_drained();
        finish_run();
    end

endmodule

`default_nettype wire

/* rename_top.f */
+incdir+source
source/rename_types_pkg.sv
source/rename_ctrl_pkg.sv
source/free_list.sv
source/rename_front.sv
source/register_renamer.sv
source/rename_out.sv
source/rename_top.sv
test/rename_checker.sv
test/tb_rename_top.sv

/* test/rename_input.txt */
# name req_valid id rs1 rs2 rd uses_rd retire_valid retire_id discard exp_rs1 exp_rs2 exp_rd exp_flight
# Decimal, one line per cycle; exp_flight is checked when the line is driven, -1 skips it
init_idle     0  0  0  0  0 0   0  0 0    0  0  0   0
init_map      1  0  5 31  0 0   0  0 0    5 31  0  -1
alloc_first   1  1  1  2  3 1   0  0 0    1  2 32  -1
alloc_second  1  2  3  4  4 1   0  0 0   32  4 33  -1
alloc_third   1  3  4  3  3 1   0  0 0   33 32 34  -1
no_rd_x0      1  4  3  4  0 1   0  0 0   34 33  0  -1
no_rd_flag    1  5  0  3  7 0   0  0 0    0 34  0  -1
alloc_after   1  6  7  0  7 1   0  0 0    7  0 35  -1
idle          0  0  0  0  0 0   0  0 0    0  0  0  -1
flight_count  0  0  0  0  0 0   0  0 0    0  0  0   7
commit_free   0  0  0  0  0 0   1  1 0    0  0  0  -1
fifo_drain    1  7  8  0  8 1   1  0 0    8  0 36  -1
fifo_drain    1  8  8  0  8 1   1  4 0   36  0 37  -1
fifo_drain    1  9  8  0  8 1   1  5 0   37  0 38  -1
fifo_drain    1 10  8  0  8 1   0  0 0   38  0 39  -1
fifo_drain    1 11  8  0  8 1   0  0 0   39  0 40  -1
fifo_drain    1 12  8  0  8 1   0  0 0   40  0 41  -1
fifo_drain    1 13  8  0  8 1   0  0 0   41  0 42  -1
fifo_drain    1 14  8  0  8 1   0  0 0   42  0 43  -1
fifo_drain    1 15  8  0  8 1   0  0 0   43  0 44  -1
fifo_drain    1 16  8  0  8 1   0  0 0   44  0 45  -1
fifo_drain    1 17  8  0  8 1   0  0 0   45  0 46  -1
fifo_drain    1 18  8  0  8 1   0  0 0   46  0 47  -1
fifo_drain    1 19  8  0  8 1   0  0 0   47  0 48  -1
fifo_drain    1 20  8  0  8 1   0  0 0   48  0 49  -1
fifo_drain    1 21  8  0  8 1   0  0 0   49  0 50  -1
fifo_drain    1 22  8  0  8 1   0  0 0   50  0 51  -1
fifo_drain    1 23  8  0  8 1   0  0 0   51  0 52  -1
fifo_drain    1 24  8  0  8 1   0  0 0   52  0 53  -1
fifo_drain    1 25  8  0  8 1   0  0 0   53  0 54  -1
fifo_drain    1 26  8  0  8 1   0  0 0   54  0 55  -1
fifo_drain    1 27  8  0  8 1   0  0 0   55  0 56  -1
fifo_drain    1 28  8  0  8 1   0  0 0   56  0 57  -1
fifo_drain    1 29  8  0  8 1   0  0 0   57  0 58  -1
fifo_drain    1 30  8  0  8 1   0  0 0   58  0 59  -1
fifo_drain    1 31  8  0  8 1   0  0 0   59  0 60  -1
fifo_drain    1  0  8  0  8 1   0  0 0   60  0 61  -1
fifo_drain    1  4  8  0  8 1   0  0 0   61  0 62  -1
fifo_drain    1  5  8  0  8 1   0  0 0   62  0 63  -1
commit_reuse  1  1  8  9  9 1   0  0 0   63  9  3  -1
discard_last  0  0  0  0  0 0   1  5 1    0  0  0  -1
discard_prev  0  0  0  0  0 0   1  1 1    0  0  0  -1
discard_read  1  5  8  9 10 1   0  0 0   62  9 63  -1
discard_tail  1  1 10  0 11 1   0  0 0   63  0  3  -1
idle          0  0  0  0  0 0   0  0 0    0  0  0  -1
flight_full   0  0  0  0  0 0   0  0 0    0  0  0  32
commit_alone  0  0  0  0  0 0   1  3 0    0  0  0  -1
commit_same   1  3  3  4 12 1   1  2 0   34 33 32  -1
idle          0  0  0  0  0 0   0  0 0    0  0  0  -1
flight_same   0  0  0  0  0 0   0  0 0    0  0  0  31
